// ==== source/rv_pkg.sv ====
package rv_pkg;

    // major opcodes of the RV32I subset
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;

    // alu operations, pass_b carries the lui immediate through
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass_b
    } alu_op_t;

    // writeback source
    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_pc_imm
    } wb_sel_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // branch offset is scattered, bit 0 implied zero
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // one instruction word, viewed per format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
    } instr_t;

endpackage

// ==== source/rv_decode.sv ====
`timescale 1ns/1ns

module rv_decode (
    input  rv_pkg::instr_t  instr,
    output logic [31:0]     imm,
    output rv_pkg::alu_op_t alu_op,
    output logic            alu_src_imm,
    output logic            reg_write,
    output logic            mem_read,
    output logic            mem_write,
    output logic            branch,
    output rv_pkg::wb_sel_t wb_sel,
    output logic            use_rs1,
    output logic            use_rs2
);

    // bit 30 of the word, sub / sra select
    logic            alt;
    // operation shared by register and immediate arithmetic
    rv_pkg::alu_op_t arith_op;

    always_comb begin
        alt = instr.r.funct7[5];
        // immediate forms only honour bit 30 on right shifts
        if (instr.r.opcode == rv_pkg::op_imm && instr.r.funct3 != 3'b101) begin
            alt = 1'b0;
        end
        case (instr.r.funct3)
            3'b000:  arith_op = alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
            3'b001:  arith_op = rv_pkg::alu_sll;
            3'b010:  arith_op = rv_pkg::alu_slt;
            3'b011:  arith_op = rv_pkg::alu_sltu;
            3'b100:  arith_op = rv_pkg::alu_xor;
            3'b101:  arith_op = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            3'b110:  arith_op = rv_pkg::alu_or;
            default: arith_op = rv_pkg::alu_and;
        endcase
    end

    always_comb begin
        // unknown opcodes fall through as a nop
        imm         = '0;
        alu_op      = rv_pkg::alu_add;
        alu_src_imm = 1'b0;
        reg_write   = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        branch      = 1'b0;
        wb_sel      = rv_pkg::wb_alu;
        use_rs1     = 1'b0;
        use_rs2     = 1'b0;
        case (instr.r.opcode)
            rv_pkg::op_reg: begin
                alu_op    = arith_op;
                reg_write = 1'b1;
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
            end
            rv_pkg::op_imm: begin
                imm         = {{20{instr.i.imm[11]}}, instr.i.imm};
                alu_op      = arith_op;
                alu_src_imm = 1'b1;
                reg_write   = 1'b1;
                use_rs1     = 1'b1;
            end
            rv_pkg::op_load: begin
                // address is rs1 plus offset
                imm         = {{20{instr.i.imm[11]}}, instr.i.imm};
                alu_src_imm = 1'b1;
                reg_write   = 1'b1;
                mem_read    = 1'b1;
                wb_sel      = rv_pkg::wb_mem;
                use_rs1     = 1'b1;
            end
            rv_pkg::op_store: begin
                imm         = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
                alu_src_imm = 1'b1;
                mem_write   = 1'b1;
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
            end
            rv_pkg::op_branch: begin
                // compare by subtraction, target built in execute
                imm     = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                           instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
                alu_op  = rv_pkg::alu_sub;
                branch  = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            rv_pkg::op_lui: begin
                imm         = {instr.u.imm, 12'b0};
                alu_op      = rv_pkg::alu_pass_b;
                alu_src_imm = 1'b1;
                reg_write   = 1'b1;
            end
            rv_pkg::op_auipc: begin
                // pc adder in execute gives the result
                imm       = {instr.u.imm, 12'b0};
                reg_write = 1'b1;
                wb_sel    = rv_pkg::wb_pc_imm;
            end
            default: begin
            end
        endcase
        // x0 is never written
        if (instr.r.rd == 5'd0) begin
            reg_write = 1'b0;
        end
    end

endmodule

// ==== source/rv_regfile.sv ====
`timescale 1ns/1ns

module rv_regfile (
    input  logic        CLK,
    input  logic        RESET_N,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic [31:0] wdata,
    input  logic        we,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    // x1 to x31, x0 has no storage
    logic [31:0] regs [1:31];

    // one read port, writeback value wins over the stored one
    function automatic logic [31:0] read_port(input logic [4:0] sel);
        logic [31:0] value;
        if (sel == 5'd0) begin
            value = '0;
        end else if (we && rd == sel) begin
            value = wdata;
        end else begin
            value = regs[sel];
        end
        return value;
    endfunction

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int k = 1; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    always_comb begin
        rdata1 = read_port(rs1);
        rdata2 = read_port(rs2);
    end

    // decode strips writes to x0 before they reach writeback
    assert property (@(posedge CLK) disable iff (!RESET_N) !(we && rd == 5'd0))
        else $error("rv_regfile: write strobe with rd = x0");

endmodule

// ==== source/rv_alu.sv ====
`timescale 1ns/1ns

module rv_alu (
    input  logic [31:0]     a,
    input  logic [31:0]     b,
    input  rv_pkg::alu_op_t op,
    output logic [31:0]     result,
    output logic            zero
);

    // shift amount, upper bits of b ignored
    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            rv_pkg::alu_add:    result = a + b;
            rv_pkg::alu_sub:    result = a - b;
            rv_pkg::alu_and:    result = a & b;
            rv_pkg::alu_or:     result = a | b;
            rv_pkg::alu_xor:    result = a ^ b;
            // signed compare
            rv_pkg::alu_slt:    result = {31'b0, $signed(a) < $signed(b)};
            rv_pkg::alu_sltu:   result = {31'b0, a < b};
            rv_pkg::alu_sll:    result = a << shamt;
            rv_pkg::alu_srl:    result = a >> shamt;
            // arithmetic shift keeps the sign
            rv_pkg::alu_sra:    result = $unsigned($signed(a) >>> shamt);
            rv_pkg::alu_pass_b: result = b;
            default:            result = '0;
        endcase
    end

    // beq / bne test this after sub
    assign zero = (result == 32'd0);

endmodule

// ==== source/rv_hazard.sv ====
`timescale 1ns/1ns

module rv_hazard (
    input  logic [4:0] rs1,
    input  logic [4:0] rs2,
    input  logic       use_rs1,
    input  logic       use_rs2,
    input  logic [4:0] ex_rd,
    input  logic       ex_write,
    input  logic [4:0] mem_rd,
    input  logic       mem_write_reg,
    input  logic       branch_taken,
    output logic       stall,
    output logic       flush
);

    // pending write to a used source still in execute or memory
    logic raw1;
    logic raw2;

    // writeback needs no check as the register file bypasses it
    assign raw1 = use_rs1 && ((ex_write && ex_rd == rs1) || (mem_write_reg && mem_rd == rs1));
    assign raw2 = use_rs2 && ((ex_write && ex_rd == rs2) || (mem_write_reg && mem_rd == rs2));

    // taken branch kills the younger three
    assign flush = branch_taken;

    // the flushed decode slot must not hold the pc
    assign stall = (raw1 || raw2) && !flush;

endmodule

// ==== source/rv_core.sv ====
`timescale 1ns/1ns

module rv_core #(
    parameter int ADDR_SIZE = 10
) (
    input  logic                 CLK,
    input  logic                 RESET_N,
    input  logic [31:0]          idata,
    input  logic [31:0]          ddata_r,
    output logic [ADDR_SIZE-1:0] iaddr,
    output logic [ADDR_SIZE-1:0] daddr,
    output logic [31:0]          ddata_w,
    output logic                 mem_write,
    output logic                 mem_read,
    output logic                 reg_write_enable,
    output logic [4:0]           write_register,
    output logic [31:0]          reg_write_data
);

    // byte address width of the pc
    localparam int PC_W = ADDR_SIZE + 2;

    logic [PC_W-1:0] pc;
    logic            stall;
    logic            flush;
    logic            branch_taken;

    // IF/ID
    logic            if_id_valid;
    logic [PC_W-1:0] if_id_pc;
    rv_pkg::instr_t  if_id_instr;

    // decode outputs
    logic [31:0]     dec_imm;
    rv_pkg::alu_op_t dec_alu_op;
    logic            dec_alu_src_imm;
    logic            dec_reg_write;
    logic            dec_mem_read;
    logic            dec_mem_write;
    logic            dec_branch;
    rv_pkg::wb_sel_t dec_wb_sel;
    logic            dec_use_rs1;
    logic            dec_use_rs2;
    logic [31:0]     rs1_data;
    logic [31:0]     rs2_data;

    // ID/EX
    logic            id_ex_valid;
    logic            id_ex_reg_write;
    logic            id_ex_mem_read;
    logic            id_ex_mem_write;
    logic            id_ex_branch;
    rv_pkg::alu_op_t id_ex_alu_op;
    logic            id_ex_alu_src_imm;
    rv_pkg::wb_sel_t id_ex_wb_sel;
    logic [PC_W-1:0] id_ex_pc;
    logic [31:0]     id_ex_rs1_data;
    logic [31:0]     id_ex_rs2_data;
    logic [31:0]     id_ex_imm;
    logic [4:0]      id_ex_rd;
    logic [2:0]      id_ex_funct3;

    // execute
    logic [31:0]     alu_b;
    logic [31:0]     alu_result;
    logic            alu_zero;
    logic [31:0]     pc_imm;

    // EX/MEM
    logic            ex_mem_valid;
    logic            ex_mem_reg_write;
    logic            ex_mem_mem_read;
    logic            ex_mem_mem_write;
    logic            ex_mem_branch;
    rv_pkg::wb_sel_t ex_mem_wb_sel;
    logic [31:0]     ex_mem_alu_result;
    logic            ex_mem_zero;
    logic [31:0]     ex_mem_rs2_data;
    logic [31:0]     ex_mem_pc_imm;
    logic [4:0]      ex_mem_rd;
    logic [2:0]      ex_mem_funct3;

    // MEM/WB
    logic            mem_wb_valid;
    logic            mem_wb_reg_write;
    rv_pkg::wb_sel_t mem_wb_wb_sel;
    logic [31:0]     mem_wb_alu_result;
    logic [31:0]     mem_wb_load_data;
    logic [31:0]     mem_wb_pc_imm;
    logic [4:0]      mem_wb_rd;

    // fetch with the branch target beating stall
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc <= '0;
        end else if (flush) begin
            pc <= ex_mem_pc_imm[PC_W-1:0];
        end else if (!stall) begin
            pc <= pc + PC_W'(4);
        end
    end

    assign iaddr = pc[PC_W-1:2];

    rv_decode i_decode (
        .instr       (if_id_instr),
        .imm         (dec_imm),
        .alu_op      (dec_alu_op),
        .alu_src_imm (dec_alu_src_imm),
        .reg_write   (dec_reg_write),
        .mem_read    (dec_mem_read),
        .mem_write   (dec_mem_write),
        .branch      (dec_branch),
        .wb_sel      (dec_wb_sel),
        .use_rs1     (dec_use_rs1),
        .use_rs2     (dec_use_rs2)
    );

    // written from writeback and read by decode
    rv_regfile i_regfile (
        .CLK     (CLK),
        .RESET_N (RESET_N),
        .rs1     (if_id_instr.r.rs1),
        .rs2     (if_id_instr.r.rs2),
        .rd      (mem_wb_rd),
        .wdata   (reg_write_data),
        .we      (reg_write_enable),
        .rdata1  (rs1_data),
        .rdata2  (rs2_data)
    );

    // only live stages take part in the interlock
    rv_hazard i_hazard (
        .rs1           (if_id_instr.r.rs1),
        .rs2           (if_id_instr.r.rs2),
        .use_rs1       (if_id_valid && dec_use_rs1),
        .use_rs2       (if_id_valid && dec_use_rs2),
        .ex_rd         (id_ex_rd),
        .ex_write      (id_ex_valid && id_ex_reg_write),
        .mem_rd        (ex_mem_rd),
        .mem_write_reg (ex_mem_valid && ex_mem_reg_write),
        .branch_taken  (branch_taken),
        .stall         (stall),
        .flush         (flush)
    );

    // execute
    assign alu_b = id_ex_alu_src_imm ? id_ex_imm : id_ex_rs2_data;

    rv_alu i_alu (
        .a      (id_ex_rs1_data),
        .b      (alu_b),
        .op     (id_ex_alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    // branch target and auipc result share one adder
    assign pc_imm = 32'(id_ex_pc) + id_ex_imm;

    // valid bits and control strobes
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            if_id_valid      <= 1'b0;
            id_ex_valid      <= 1'b0;
            id_ex_reg_write  <= 1'b0;
            id_ex_mem_read   <= 1'b0;
            id_ex_mem_write  <= 1'b0;
            id_ex_branch     <= 1'b0;
            ex_mem_valid     <= 1'b0;
            ex_mem_reg_write <= 1'b0;
            ex_mem_mem_read  <= 1'b0;
            ex_mem_mem_write <= 1'b0;
            ex_mem_branch    <= 1'b0;
            mem_wb_valid     <= 1'b0;
            mem_wb_reg_write <= 1'b0;
        end else begin
            // IF/ID holds on stall
            if (flush) begin
                if_id_valid <= 1'b0;
            end else if (!stall) begin
                if_id_valid <= 1'b1;
            end
            // bubble into execute while decode waits
            id_ex_valid      <= if_id_valid && !stall && !flush;
            id_ex_reg_write  <= dec_reg_write;
            id_ex_mem_read   <= dec_mem_read;
            id_ex_mem_write  <= dec_mem_write;
            id_ex_branch     <= dec_branch;
            ex_mem_valid     <= id_ex_valid && !flush;
            ex_mem_reg_write <= id_ex_reg_write;
            ex_mem_mem_read  <= id_ex_mem_read;
            ex_mem_mem_write <= id_ex_mem_write;
            ex_mem_branch    <= id_ex_branch;
            // the branch itself retires
            mem_wb_valid     <= ex_mem_valid;
            mem_wb_reg_write <= ex_mem_reg_write;
        end
    end

    // datapath payload
    always_ff @(posedge CLK) begin
        if (!stall) begin
            if_id_pc    <= pc;
            if_id_instr <= idata;
        end
        id_ex_alu_op      <= dec_alu_op;
        id_ex_alu_src_imm <= dec_alu_src_imm;
        id_ex_wb_sel      <= dec_wb_sel;
        id_ex_pc          <= if_id_pc;
        id_ex_rs1_data    <= rs1_data;
        id_ex_rs2_data    <= rs2_data;
        id_ex_imm         <= dec_imm;
        id_ex_rd          <= if_id_instr.r.rd;
        id_ex_funct3      <= if_id_instr.r.funct3;
        ex_mem_wb_sel     <= id_ex_wb_sel;
        ex_mem_alu_result <= alu_result;
        ex_mem_zero       <= alu_zero;
        ex_mem_rs2_data   <= id_ex_rs2_data;
        ex_mem_pc_imm     <= pc_imm;
        ex_mem_rd         <= id_ex_rd;
        ex_mem_funct3     <= id_ex_funct3;
        mem_wb_wb_sel     <= ex_mem_wb_sel;
        mem_wb_alu_result <= ex_mem_alu_result;
        mem_wb_load_data  <= ddata_r;
        mem_wb_pc_imm     <= ex_mem_pc_imm;
        mem_wb_rd         <= ex_mem_rd;
    end

    // bne on funct3 001 and beq otherwise
    assign branch_taken = ex_mem_valid && ex_mem_branch &&
                          ((ex_mem_funct3 == 3'b001) ? !ex_mem_zero : ex_mem_zero);

    // word addressed data memory port
    assign daddr     = ex_mem_alu_result[PC_W-1:2];
    assign ddata_w   = ex_mem_rs2_data;
    assign mem_write = ex_mem_valid && ex_mem_mem_write;
    assign mem_read  = ex_mem_valid && ex_mem_mem_read;

    // writeback select
    assign reg_write_enable = mem_wb_valid && mem_wb_reg_write;
    assign write_register   = mem_wb_rd;

    always_comb begin
        case (mem_wb_wb_sel)
            rv_pkg::wb_mem:    reg_write_data = mem_wb_load_data;
            rv_pkg::wb_pc_imm: reg_write_data = mem_wb_pc_imm;
            default:           reg_write_data = mem_wb_alu_result;
        endcase
    end

    assert property (@(posedge CLK) disable iff (!RESET_N) !(mem_write && mem_read))
        else $error("rv_core: mem_write and mem_read high together");

    // the slot behind a taken branch was flushed so it neither accesses memory nor branches
    assert property (@(posedge CLK) disable iff (!RESET_N)
        branch_taken |=> !mem_write && !mem_read && !branch_taken)
        else $error("rv_core: memory stage busy right after a taken branch");

endmodule

// ==== verif/rv_model.svh ====
// architectural state of the model
logic [31:0] model_regs [0:31];
logic [31:0] model_mem [0:MEM_WORDS-1];

// compare one dut value with its expected value
task automatic compare_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
        errors++;
        $display("error %s: got %08h expected %08h at %0t", name, got, exp, $time);
    end
endtask

// power-up data memory contents mixing every address bit
function automatic logic [31:0] data_fill_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ {addr[15:0], ~addr[15:0]};
endfunction

// filler for unused program slots where opcode 0 decodes as a nop
function automatic logic [31:0] code_fill_word(input logic [31:0] addr);
    return ((addr * 32'h0f1e_2d3b) ^ {addr[7:0], addr[31:8]}) & 32'hffff_ff80;
endfunction

function automatic logic [31:0] sign_extend12(input logic [11:0] v);
    return {{20{v[11]}}, v};
endfunction

// mostly x0 to x5 so that neighbours depend on each other
function automatic logic [4:0] pick_reg();
    logic [4:0] r;
    if ($urandom_range(3, 0) != 0) begin
        r = 5'($urandom_range(5, 0));
    end else begin
        r = 5'($urandom_range(31, 0));
    end
    return r;
endfunction

// isa arithmetic with alt as bit 30 for sub and sra
function automatic logic [31:0] arith(input logic [2:0] f3, input logic alt,
                                      input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
        3'b000:  r = alt ? a - b : a + b;
        3'b001:  r = a << b[4:0];
        3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011:  r = (a < b) ? 32'd1 : 32'd0;
        3'b100:  r = a ^ b;
        3'b110:  r = a | b;
        3'b111:  r = a & b;
        default: begin
            if (alt) begin
                r = $unsigned($signed(a) >>> b[4:0]);
            end else begin
                r = a >> b[4:0];
            end
        end
    endcase
    return r;
endfunction

// random program of PROG_LEN words, then a beq x0,x0,0 self-loop
function automatic void build_program();
    rv_pkg::instr_t w;
    int             kind;
    logic [2:0]     f3;
    logic           alt;
    int             span;
    logic [12:0]    boff;
    logic [11:0]    simm;
    for (int a = 0; a < MEM_WORDS; a++) begin
        imem[a] = code_fill_word(32'(a));
    end
    for (int n = 0; n < PROG_LEN; n++) begin
        w    = '0;
        kind = $urandom_range(15, 0);
        f3   = 3'($urandom_range(7, 0));
        alt  = 1'($urandom_range(1, 0));
        if (kind <= 4) begin
            w.r.opcode = rv_pkg::op_reg;
            w.r.rd     = pick_reg();
            w.r.rs1    = pick_reg();
            w.r.rs2    = pick_reg();
            w.r.funct3 = f3;
            // only add/sub and srl/sra have a second form
            w.r.funct7 = (alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
        end else if (kind <= 8) begin
            w.i.opcode = rv_pkg::op_imm;
            w.i.rd     = pick_reg();
            w.i.rs1    = pick_reg();
            w.i.funct3 = f3;
            if (f3 == 3'b001) begin
                w.i.imm = {7'h00, 5'($urandom_range(31, 0))};
            end else if (f3 == 3'b101) begin
                w.i.imm = {alt ? 7'h20 : 7'h00, 5'($urandom_range(31, 0))};
            end else begin
                w.i.imm = 12'($urandom());
            end
        end else if (kind <= 10) begin
            w.u.opcode = (kind == 9) ? rv_pkg::op_lui : rv_pkg::op_auipc;
            w.u.rd     = pick_reg();
            w.u.imm    = 20'($urandom());
        end else if (kind <= 12) begin
            // word loads in a 64-word window off x0
            w.i.opcode = rv_pkg::op_load;
            w.i.funct3 = 3'b010;
            w.i.rd     = pick_reg();
            w.i.imm    = 12'($urandom_range(63, 0) * 4);
        end else if (kind == 13) begin
            simm       = 12'($urandom_range(63, 0) * 4);
            w.s.opcode = rv_pkg::op_store;
            w.s.funct3 = 3'b010;
            w.s.rs2    = pick_reg();
            w.s.imm_hi = simm[11:5];
            w.s.imm_lo = simm[4:0];
        end else begin
            // forward only and never past the final loop
            span = (PROG_LEN - n > 6) ? 6 : PROG_LEN - n;
            boff = 13'($urandom_range(span, 1) * 4);
            w.b.opcode   = rv_pkg::op_branch;
            w.b.funct3   = (kind == 14) ? 3'b000 : 3'b001;
            w.b.rs1      = pick_reg();
            w.b.rs2      = pick_reg();
            w.b.imm_12   = boff[12];
            w.b.imm_11   = boff[11];
            w.b.imm_10_5 = boff[10:5];
            w.b.imm_4_1  = boff[4:1];
        end
        imem[n] = w;
    end
    w          = '0;
    w.b.opcode = rv_pkg::op_branch;
    imem[PROG_LEN] = w;
endfunction

// run the program in order up to the final loop and fill the expected queues
function automatic void run_model();
    rv_pkg::instr_t w;
    int             pc_idx;
    int             next_idx;
    int             steps;
    logic [31:0]    a;
    logic [31:0]    b;
    logic [31:0]    res;
    logic [31:0]    addr;
    logic [12:0]    boff;
    logic           writes;
    for (int k = 0; k < 32; k++) begin
        model_regs[k] = '0;
    end
    for (int k = 0; k < MEM_WORDS; k++) begin
        model_mem[k] = data_fill_word(32'(k));
    end
    pc_idx = 0;
    steps  = 0;
    while (pc_idx != PROG_LEN && steps < 4 * PROG_LEN) begin
        w        = imem[pc_idx];
        a        = model_regs[w.r.rs1];
        b        = model_regs[w.r.rs2];
        res      = '0;
        writes   = 1'b1;
        next_idx = pc_idx + 1;
        case (w.r.opcode)
            rv_pkg::op_reg:   res = arith(w.r.funct3, w.r.funct7[5], a, b);
            rv_pkg::op_imm:   res = arith(w.i.funct3, w.i.funct3 == 3'b101 && w.i.imm[10],
                                          a, sign_extend12(w.i.imm));
            rv_pkg::op_lui:   res = {w.u.imm, 12'h000};
            rv_pkg::op_auipc: res = 32'(pc_idx * 4) + {w.u.imm, 12'h000};
            rv_pkg::op_load: begin
                addr = a + sign_extend12(w.i.imm);
                res  = model_mem[ADDR_SIZE'(addr >> 2)];
            end
            rv_pkg::op_store: begin
                writes = 1'b0;
                addr   = a + sign_extend12({w.s.imm_hi, w.s.imm_lo});
                model_mem[ADDR_SIZE'(addr >> 2)] = b;
                exp_st_addr.push_back(ADDR_SIZE'(addr >> 2));
                exp_st_data.push_back(b);
            end
            rv_pkg::op_branch: begin
                writes = 1'b0;
                boff   = {w.b.imm_12, w.b.imm_11, w.b.imm_10_5, w.b.imm_4_1, 1'b0};
                if ((w.b.funct3 == 3'b001) ? (a != b) : (a == b)) begin
                    next_idx = pc_idx + int'(boff[12:2]);
                end
            end
            default: writes = 1'b0;
        endcase
        // x0 stays zero and never shows up as a write
        if (writes && w.r.rd != 5'd0) begin
            model_regs[w.r.rd] = res;
            exp_wr_reg.push_back(w.r.rd);
            exp_wr_data.push_back(res);
        end
        pc_idx = next_idx;
        steps++;
    end
endfunction

// ==== verif/rv_core_tb.sv ====
`timescale 1ns/1ns

module rv_core_tb;

    localparam int ADDR_SIZE       = 10;
    localparam int MEM_WORDS       = 1 << ADDR_SIZE;
    localparam int PROG_LEN        = 200;
    localparam int QUIET_CYCLES    = 20;
    // worst case per instruction is a two-cycle stall plus a three-cycle flush
    localparam int WATCHDOG_CYCLES = PROG_LEN * 6 + 100;

    logic                 CLK;
    logic                 RESET_N;
    logic [31:0]          idata;
    logic [31:0]          ddata_r;
    logic [ADDR_SIZE-1:0] iaddr;
    logic [ADDR_SIZE-1:0] daddr;
    logic [31:0]          ddata_w;
    logic                 mem_write;
    logic                 mem_read;
    logic                 reg_write_enable;
    logic [4:0]           write_register;
    logic [31:0]          reg_write_data;

    // instruction and data memories
    logic [31:0] imem [0:MEM_WORDS-1];
    logic [31:0] dmem [0:MEM_WORDS-1];

    // expected results in program order
    logic [4:0]           exp_wr_reg  [$];
    logic [31:0]          exp_wr_data [$];
    logic [ADDR_SIZE-1:0] exp_st_addr [$];
    logic [31:0]          exp_st_data [$];

    int errors      = 0;
    int wr_idx      = 0;
    int st_idx      = 0;
    int live_cycles = 0;

    `include "rv_model.svh"

    rv_core #(
        .ADDR_SIZE (ADDR_SIZE)
    ) i_dut (
        .CLK              (CLK),
        .RESET_N          (RESET_N),
        .idata            (idata),
        .ddata_r          (ddata_r),
        .iaddr            (iaddr),
        .daddr            (daddr),
        .ddata_w          (ddata_w),
        .mem_write        (mem_write),
        .mem_read         (mem_read),
        .reg_write_enable (reg_write_enable),
        .write_register   (write_register),
        .reg_write_data   (reg_write_data)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // both memories answer in the same cycle
    assign idata   = imem[iaddr];
    assign ddata_r = dmem[daddr];

    always @(posedge CLK) begin
        if (mem_write) begin
            dmem[daddr] <= ddata_w;
        end
    end

    // edges since reset was released
    always @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            live_cycles <= 0;
        end else begin
            live_cycles <= live_cycles + 1;
        end
    end

    task automatic report_counts();
        $display("summary: %0d errors, %0d of %0d writebacks and %0d of %0d stores checked",
                 errors, wr_idx, exp_wr_reg.size(), st_idx, exp_st_addr.size());
    endtask

    // scoreboard sampling on the falling edge
    always @(negedge CLK) begin
        if (live_cycles <= 2) begin
            // pc sits at zero until the first fetch edge
            if (live_cycles == 0) begin
                compare_value("iaddr", 32'(iaddr), 32'd0);
            end
            // first instruction cannot be in memory or writeback yet
            compare_value("mem_write", 32'(mem_write), 32'd0);
            compare_value("mem_read", 32'(mem_read), 32'd0);
            compare_value("reg_write_enable", 32'(reg_write_enable), 32'd0);
        end else begin
            if (reg_write_enable) begin
                if (write_register == 5'd0) begin
                    errors++;
                    $display("writeback strobe names register x0 at %0t", $time);
                end
                if (wr_idx < exp_wr_reg.size()) begin
                    compare_value("write_register", 32'(write_register),
                                  32'(exp_wr_reg[wr_idx]));
                    compare_value("reg_write_data", reg_write_data, exp_wr_data[wr_idx]);
                    wr_idx++;
                end else begin
                    errors++;
                    $display("extra register write to x%0d after the last expected one at %0t",
                             write_register, $time);
                end
            end
            if (mem_write) begin
                if (st_idx < exp_st_addr.size()) begin
                    compare_value("daddr", 32'(daddr), 32'(exp_st_addr[st_idx]));
                    compare_value("ddata_w", ddata_w, exp_st_data[st_idx]);
                    st_idx++;
                end else begin
                    errors++;
                    $display("extra store to word %0h after the last expected one at %0t",
                             daddr, $time);
                end
            end
        end
    end

    initial begin
        RESET_N = 1'b0;
        void'($urandom(32'h085ad074));
        build_program();
        for (int a = 0; a < MEM_WORDS; a++) begin
            dmem[a] = data_fill_word(32'(a));
        end
        run_model();
        $display("model: %0d register writes, %0d stores", exp_wr_reg.size(),
                 exp_st_addr.size());
        repeat (3) @(negedge CLK);
        RESET_N = 1'b1;
        // drain the expected queues, then make sure nothing else retires
        while (wr_idx < exp_wr_reg.size() || st_idx < exp_st_addr.size()) begin
            @(posedge CLK);
        end
        repeat (QUIET_CYCLES) @(posedge CLK);
        report_counts();
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        $display("timeout: the core stopped retiring results within %0d cycles, the run hung",
                 WATCHDOG_CYCLES);
        report_counts();
        $display("Test failures found");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+verif
source/rv_pkg.sv
source/rv_decode.sv
source/rv_regfile.sv
source/rv_alu.sv
source/rv_hazard.sv
source/rv_core.sv
verif/rv_core_tb.sv

// ==== Makefile ====
TOP = rv_core_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log
